/* bench/uart_chk.sv */
// uart testbench checker
// reference queue for received entries, credit bookkeeping, txd frame shape

`timescale 1ns/10ps
`default_nettype none

module uart_chk #(
  parameter int bdr = 7
) (
  input  wire logic                         clk,
  input  wire logic                         rst,
  // host transmit side plus the expectation flags sent with each byte
  input  wire logic                         tx_vld,
  input  wire logic [uart_pkg::uart_dw-1:0] tx_dat,
  input  wire logic                         exp_err,
  input  wire logic                         exp_skip,
  input  wire logic                         tx_crd,
  // serial line and host receive side
  input  wire logic                         txd,
  input  wire logic                         rx_vld,
  input  wire logic [uart_pkg::uart_dw-1:0] rx_dat,
  input  wire logic                         rx_err,
  input  wire logic                         rx_rdy,
  input  wire logic                         rx_ovf,
  input  wire logic                         ovf_allow,
  // counts for the closing report
  output int                                err_cnt,
  output int                                cmp_cnt,
  output int                                pend,
  output int                                frm_cnt
);

  import uart_pkg::*;

  // bit period and mid-bit offset
  localparam int per = bdr + 1;
  localparam int mid = per / 2;

  // expected rx entries and bytes still to appear on txd
  logic [uart_dw:0]   rxq [$];
  logic [uart_dw-1:0] txq [$];
  logic [uart_dw:0]   exp_ent;

  int errs = 0;
  int cmps = 0;
  int npend = 0;
  int frames = 0;
  int sent = 0;
  int crd = 0;

  logic post_done = 1'b0;
  logic ovf_seen = 1'b0;
  logic txd_prev = 1'b1;
  // txd frame tracker
  logic               frm_run = 1'b0;
  int                 frm_pos = 0;
  int                 frm_bit = 0;
  logic [uart_dw-1:0] frm_exp = '0;

  assign err_cnt = errs;
  assign cmp_cnt = cmps;
  assign pend    = npend;
  assign frm_cnt = frames;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // entry the host should read back with err only when the stop bit was spoiled
  function automatic logic [uart_dw:0] expect_entry(input logic [uart_dw-1:0] b,
                                                    input logic bad);
    return {b, bad};
  endfunction

  // line level of frame bit j with start low, data lsb first and stop high
  function automatic logic frame_bit(input logic [uart_dw-1:0] b, input int j);
    if (j == 0) begin
      return 1'b0;
    end
    if (j <= int'(uart_dw)) begin
      return b[j-1];
    end
    return 1'b1;
  endfunction

  task automatic value_err(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
    errs++;
  endtask

  task automatic fail_msg(input string what);
    $display("error at %0t: %s", $time, what);
    errs++;
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  // first cycle out of reset
  task automatic reset_state();
    if (!post_done) begin
      post_done = 1'b1;
      if (txd != 1'b1) value_err("txd", 32'(1'b1), 32'(txd));
      if (rx_vld != 1'b0) value_err("rx_vld", 32'(1'b0), 32'(rx_vld));
      if (rx_ovf != 1'b0) value_err("rx_ovf", 32'(1'b0), 32'(rx_ovf));
      if (tx_crd != 1'b0) value_err("tx_crd", 32'(1'b0), 32'(tx_crd));
    end
  endtask

  task automatic host_side();
    if (tx_vld) begin
      sent++;
      txq.push_back(tx_dat);
      // dropped frames never reach the host
      if (!exp_skip) begin
        rxq.push_back(expect_entry(tx_dat, exp_err));
      end
    end
    if (tx_crd) begin
      crd++;
    end
    if (crd > sent) fail_msg("credit returned for a byte never sent");
    if (sent - crd > int'(uart_tx_depth)) fail_msg("more bytes outstanding than tx entries");
    if (rx_ovf && !ovf_allow && !ovf_seen) begin
      ovf_seen = 1'b1;
      value_err("rx_ovf", 32'(1'b0), 32'(rx_ovf));
    end
  endtask

  task automatic rx_side();
    if (rx_vld && rx_rdy) begin
      if (rxq.size() == 0) begin
        fail_msg("host read an entry that was never sent");
      end else begin
        exp_ent = rxq.pop_front();
        cmps++;
        if (rx_dat != exp_ent[uart_dw:1]) begin
          value_err("rx_dat", 32'(exp_ent[uart_dw:1]), 32'(rx_dat));
        end
        if (rx_err != exp_ent[0]) value_err("rx_err", 32'(exp_ent[0]), 32'(rx_err));
      end
    end
  endtask

  // start on a falling txd while idle and sample each bit in its middle
  task automatic frame_side();
    if (!frm_run) begin
      if (txd_prev && !txd) begin
        frm_run = 1'b1;
        frm_pos = 0;
        if (txq.size() == 0) begin
          fail_msg("frame on txd with no byte sent");
          frm_exp = '0;
        end else begin
          frm_exp = txq.pop_front();
        end
      end
    end else begin
      frm_pos++;
    end
    if (frm_run && (frm_pos % per == mid)) begin
      frm_bit = frm_pos / per;
      cmps++;
      if (txd != frame_bit(frm_exp, frm_bit)) begin
        value_err($sformatf("txd bit %0d", frm_bit), 32'(frame_bit(frm_exp, frm_bit)),
                  32'(txd));
      end
      // stop bit done
      if (frm_bit == int'(uart_dw) + 1) begin
        frm_run = 1'b0;
        frames++;
      end
    end
    txd_prev = txd;
  endtask

  // inputs settle 1 ns after the edge so the edge sees stable values
  always @(posedge clk) begin
    if (rst) begin
      txd_prev = 1'b1;
    end else begin
      reset_state();
      host_side();
      rx_side();
      frame_side();
      npend = rxq.size();
    end
  end

endmodule : uart_chk

`default_nettype wire

/* bench/uart_tb.sv */
// uart controller testbench
// credit host with lfsr data, txd looped back to rxd, closing report

`timescale 1ns/10ps
`default_nettype none

module uart_tb;

  import uart_pkg::*;

  // 8 clocks per bit
  localparam int          bdr_val  = 7;
  localparam int          per      = bdr_val + 1;
  localparam int          wait_max = 2000;
  localparam logic [15:0] seed     = 16'd2145;

  logic               clk;
  logic               rst;
  logic               tx_vld;
  logic [uart_dw-1:0] tx_dat;
  logic               tx_crd;
  logic               txd;
  logic               rxd;
  logic               rx_vld;
  logic [uart_dw-1:0] rx_dat;
  logic               rx_err;
  logic               rx_rdy = 1'b1;
  logic               rx_ovf;

  // line fault and checker hints
  logic force_low;
  logic exp_err;
  logic exp_skip;
  logic ovf_allow;

  // 0 ready, 1 random stalls, 2 held low
  logic [1:0] rdy_mode;
  logic [1:0] rdy_mode_q = 2'd0;

  // one lfsr state per process
  logic [15:0] byte_st = seed;
  logic [15:0] stall_st = seed;

  logic [uart_dw-1:0] byt;
  int crd_cnt = 0;
  int sent_cnt = 0;
  int host_errs = 0;
  int chk_errs;
  int cmp_cnt;
  int pend;
  int frm_cnt;
  int frm_base;
  int i;

  //////////////////////////////
  // clock, dut, loopback
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign rxd = force_low ? 1'b0 : txd;

  uart_ctl DUT (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (uart_cw'(bdr_val)),
    .tx_vld  (tx_vld),
    .tx_dat  (tx_dat),
    .tx_crd  (tx_crd),
    .txd     (txd),
    .rxd     (rxd),
    .rx_vld  (rx_vld),
    .rx_dat  (rx_dat),
    .rx_err  (rx_err),
    .rx_rdy  (rx_rdy),
    .rx_ovf  (rx_ovf)
  );

  uart_chk #(.bdr(bdr_val)) chk (
    .clk       (clk),
    .rst       (rst),
    .tx_vld    (tx_vld),
    .tx_dat    (tx_dat),
    .exp_err   (exp_err),
    .exp_skip  (exp_skip),
    .tx_crd    (tx_crd),
    .txd       (txd),
    .rx_vld    (rx_vld),
    .rx_dat    (rx_dat),
    .rx_err    (rx_err),
    .rx_rdy    (rx_rdy),
    .rx_ovf    (rx_ovf),
    .ovf_allow (ovf_allow),
    .err_cnt   (chk_errs),
    .cmp_cnt   (cmp_cnt),
    .pend      (pend),
    .frm_cnt   (frm_cnt)
  );

  //////////////////////////////
  // host helpers
  //////////////////////////////

  // galois form with taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_byte(output logic [uart_dw-1:0] b);
    for (int k = 0; k < int'(uart_dw); k++) begin
      byte_st = lfsr_next(byte_st);
      b[k] = byte_st[0];
    end
  endtask

  // next edge and then the drive offset
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic host_err(input string what);
    $display("error at %0t: %s", $time, what);
    host_errs++;
  endtask

  // returned credits
  always @(posedge clk) begin
    if (tx_crd) begin
      crd_cnt <= crd_cnt + 1;
    end
  end

  // mode taken at the edge and level driven after it
  always @(posedge clk) begin
    rdy_mode_q = rdy_mode;
    #1;
    case (rdy_mode_q)
      2'd1: begin
        stall_st = lfsr_next(stall_st);
        rx_rdy = stall_st[0];
      end
      2'd2:    rx_rdy = 1'b0;
      default: rx_rdy = 1'b1;
    endcase
  end

  // spend one credit and wait for one if none is left
  task automatic send_byte(input logic [uart_dw-1:0] b, input logic bad, input logic skip);
    int n;
    n = 0;
    while ((sent_cnt - crd_cnt >= int'(uart_tx_depth)) && (n < wait_max)) begin
      tick();
      n++;
    end
    if (n >= wait_max) begin
      host_err("no tx credit came back");
    end else begin
      tx_vld = 1'b1;
      tx_dat = b;
      exp_err = bad;
      exp_skip = skip;
      sent_cnt++;
      if (sent_cnt - crd_cnt > int'(uart_tx_depth)) host_err("host went past its credits");
      tick();
      tx_vld = 1'b0;
      exp_err = 1'b0;
      exp_skip = 1'b0;
    end
  endtask

  // all entries read and all credits home
  task automatic wait_drain();
    int n;
    n = 0;
    while (((pend != 0) || (crd_cnt != sent_cnt)) && (n < wait_max)) begin
      tick();
      n++;
    end
    if (n >= wait_max) host_err("sent bytes did not come back");
  endtask

  task automatic wait_txd_fall();
    int n;
    n = 0;
    while (txd && (n < wait_max)) begin
      tick();
      n++;
    end
    if (n >= wait_max) host_err("no start bit on txd");
  endtask

  task automatic wait_frames(input int target);
    int n;
    n = 0;
    while ((frm_cnt < target) && (n < wait_max)) begin
      tick();
      n++;
    end
    if (n >= wait_max) host_err("frames on txd stopped early");
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    rst = 1'b1;
    tx_vld = 1'b0;
    tx_dat = '0;
    exp_err = 1'b0;
    exp_skip = 1'b0;
    force_low = 1'b0;
    ovf_allow = 1'b0;
    rdy_mode = 2'd0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    tick();

    // single round trip
    send_byte(8'hA5, 1'b0, 1'b0);
    wait_drain();

    // burst under credits
    for (i = 0; i < 40; i++) begin
      take_byte(byt);
      send_byte(byt, 1'b0, 1'b0);
    end
    wait_drain();

    // random host stalls where the drain still outpaces the line
    rdy_mode = 2'd1;
    for (i = 0; i < 16; i++) begin
      take_byte(byt);
      send_byte(byt, 1'b0, 1'b0);
    end
    wait_drain();
    rdy_mode = 2'd0;

    // line held low across the stop bit
    take_byte(byt);
    send_byte(byt, 1'b1, 1'b0);
    wait_txd_fall();
    repeat ((int'(uart_dw) + 1) * per) tick();
    force_low = 1'b1;
    repeat (per) tick();
    force_low = 1'b0;
    wait_drain();

    // rx fifo full so the last two frames are lost
    ovf_allow = 1'b1;
    rdy_mode = 2'd2;
    frm_base = frm_cnt;
    for (i = 0; i < int'(uart_rx_depth) + 2; i++) begin
      take_byte(byt);
      send_byte(byt, 1'b0, i >= int'(uart_rx_depth));
    end
    wait_frames(frm_base + int'(uart_rx_depth) + 2);
    // the push trails the txd stop sample by the synchronizer delay
    repeat (per) tick();
    if (rx_ovf != 1'b1) begin
      $display("ERR %0t rx_ovf exp 1 got %0b", $time, rx_ovf);
      host_errs++;
    end
    rdy_mode = 2'd0;
    wait_drain();
    repeat (per) tick();

    $display("compares %0d, checker errors %0d, host errors %0d",
             cmp_cnt, chk_errs, host_errs);
    if ((chk_errs == 0) && (host_errs == 0) && (cmp_cnt > 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : uart_tb

`default_nettype wire

/* files.f */
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_ser.sv
logic/uart_des.sv
logic/uart_ctl.sv
bench/uart_chk.sv
bench/uart_tb.sv

/* logic/uart_ctl.sv */
// uart controller top
// tx fifo with credit return into the serializer, deserializer into rx fifo

`timescale 1ns/10ps
`default_nettype none

module uart_ctl (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // bit period is cfg_bdr+1 clocks with cfg_bdr at least 3
  input  wire logic [uart_pkg::uart_cw-1:0] cfg_bdr,
  // credit based host transmit
  input  wire logic                        tx_vld,
  input  wire logic [uart_pkg::uart_dw-1:0] tx_dat,
  output logic                             tx_crd,
  // serial line
  output logic                             txd,
  input  wire logic                        rxd,
  // valid/ready host receive
  output logic                             rx_vld,
  output logic [uart_pkg::uart_dw-1:0]      rx_dat,
  output logic                             rx_err,
  input  wire logic                        rx_rdy,
  // sticky flag cleared by reset only
  output logic                             rx_ovf
);

  import uart_pkg::*;

  // tx fifo head to serializer
  logic               ser_vld;
  logic               ser_rdy;
  logic [uart_dw-1:0] ser_dat;

  // deserializer to rx fifo
  logic               des_push;
  uart_rx_t           des_dat;
  logic               rx_push;
  logic               rx_full;
  uart_rx_t           rx_head;

  //////////////////////////////
  // transmit path
  //////////////////////////////

  // full left open as credits keep the host from filling it
  uart_fifo #(
    .payload_t (logic [uart_dw-1:0]),
    .depth     (uart_tx_depth)
  ) tx_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (tx_vld),
    .push_dat (tx_dat),
    .full     (),
    .vld      (ser_vld),
    .dat      (ser_dat),
    .rdy      (ser_rdy)
  );

  uart_ser ser (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .str_vld (ser_vld),
    .str_dat (ser_dat),
    .str_rdy (ser_rdy),
    .txd     (txd)
  );

  // one credit back per byte leaving the fifo
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_crd <= 1'b0;
    end else begin
      tx_crd <= ser_vld & ser_rdy;
    end
  end

  //////////////////////////////
  // receive path
  //////////////////////////////

  uart_des des (
    .clk      (clk),
    .rst      (rst),
    .cfg_bdr  (cfg_bdr),
    .rxd      (rxd),
    .push     (des_push),
    .push_dat (des_dat)
  );

  // drop the entry when there is no room
  assign rx_push = des_push & ~rx_full;

  uart_fifo #(
    .payload_t (uart_rx_t),
    .depth     (uart_rx_depth)
  ) rx_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (rx_push),
    .push_dat (des_dat),
    .full     (rx_full),
    .vld      (rx_vld),
    .dat      (rx_head),
    .rdy      (rx_rdy)
  );

  assign rx_dat = rx_head.dat;
  assign rx_err = rx_head.err;

  // lost frame flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_ovf <= 1'b0;
    end else if (des_push && rx_full) begin
      rx_ovf <= 1'b1;
    end
  end

endmodule : uart_ctl

`default_nettype wire

/* logic/uart_des.sv */
// uart deserializer
// synchronized start detect, mid-bit sampling, stop-bit check

`timescale 1ns/10ps
`default_nettype none

module uart_des (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // bit period is cfg_bdr+1 clocks
  input  wire logic [uart_pkg::uart_cw-1:0] cfg_bdr,
  // asynchronous serial line
  input  wire logic                        rxd,
  // one-cycle entry push
  output logic                             push,
  output uart_pkg::uart_rx_t               push_dat
);

  import uart_pkg::*;

  // synchronizer and edge history
  logic rxd_meta;
  logic rxd_sync;
  logic rxd_prev;
  logic rxd_fall;

  // down counter with strobe at zero
  logic [uart_cw-1:0] bdr_cnt;
  logic               bdr_end;

  // 0 start, 1..dw data, dw+1 stop
  logic [uart_bw-1:0] bit_cnt;
  logic               bit_stop;
  logic               run;

  // received data with lsb arriving first
  logic [uart_dw-1:0] shf_dat;

  //////////////////////////////
  // input synchronizer
  //////////////////////////////

  // idle level after reset is high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // start candidate
  assign rxd_fall = rxd_prev & ~rxd_sync;

  //////////////////////////////
  // baud timing
  //////////////////////////////

  // half period to the middle of start and full periods after
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
    end else if (!run) begin
      if (rxd_fall) begin
        bdr_cnt <= cfg_bdr >> 1;
      end
    end else begin
      bdr_cnt <= bdr_end ? cfg_bdr : bdr_cnt - 1'b1;
    end
  end

  // mid-bit sample strobe
  assign bdr_end = run & (bdr_cnt == '0);

  //////////////////////////////
  // frame control
  //////////////////////////////

  assign bit_stop = (bit_cnt == uart_bw'(uart_dw + 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run     <= 1'b0;
      bit_cnt <= '0;
    end else if (!run) begin
      bit_cnt <= '0;
      if (rxd_fall) begin
        run <= 1'b1;
      end
    end else if (bdr_end) begin
      // high at mid-start means a glitch so return to idle
      if ((bit_cnt == '0) && rxd_sync) begin
        run <= 1'b0;
      end else if (bit_stop) begin
        run <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // data bits only
  always_ff @(posedge clk) begin
    if (bdr_end && (bit_cnt != '0) && !bit_stop) begin
      shf_dat <= {rxd_sync, shf_dat[uart_dw-1:1]};
    end
  end

  //////////////////////////////
  // output
  //////////////////////////////

  // push lands on the stop sample
  assign push = bdr_end & bit_stop;

  always_comb begin
    push_dat.dat = shf_dat;
    push_dat.err = ~rxd_sync;
  end

  // a frame is always far longer than one cycle
  a_push_single : assert property (
    @(posedge clk) disable iff (rst)
    push |=> !push
  ) else $error("uart_des: push held two cycles");

endmodule : uart_des

`default_nettype wire

/* logic/uart_fifo.sv */
// uart synchronous fifo
// circular buffer with occupancy count and a per-instance payload type

`timescale 1ns/10ps
`default_nettype none

module uart_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned depth     = 4
) (
  input  wire logic     clk,
  input  wire logic     rst,
  // write side
  input  wire logic     push,
  input  wire payload_t push_dat,
  output logic          full,
  // valid/ready read side
  output logic          vld,
  output payload_t      dat,
  input  wire logic     rdy
);

  // pointer and count widths
  localparam int unsigned aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned nw = $clog2(depth + 1);

  // storage
  payload_t mem [depth];

  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [nw-1:0] cnt;

  logic wr_en;
  logic rd_en;

  //////////////////////////////
  // handshakes
  //////////////////////////////

  // pop on head handshake
  assign rd_en = vld & rdy;
  // a write into a full buffer only lands when the head leaves
  assign wr_en = push & (~full | rd_en);

  assign full = (cnt == nw'(depth));
  assign vld  = (cnt != '0);
  assign dat  = mem[rd_ptr];

  //////////////////////////////
  // storage and pointers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_dat;
    end
  end

  // pointers wrap at depth so any depth works
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy holds on simultaneous push and pop
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // writer must respect the space it was given
  // a push while full is legal only alongside a pop
  a_no_overflow : assert property (
    @(posedge clk) disable iff (rst)
    (push && full) |-> (vld && rdy)
  ) else $error("uart_fifo: push into full buffer");

endmodule : uart_fifo

`default_nettype wire

/* logic/uart_pkg.sv */
// uart shared definitions
// frame geometry, counter widths, fifo depths and the receive entry

`default_nettype none

package uart_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  // data bits per frame
  localparam int unsigned uart_dw = 8;
  // stop bits sent
  localparam int unsigned uart_sw = 1;
  // baud divisor width
  localparam int unsigned uart_cw = 8;

  // start + data + stop
  localparam int unsigned uart_fl = 1 + uart_dw + uart_sw;
  // bit counter width covering one whole frame
  localparam int unsigned uart_bw = $clog2(uart_fl);

  //////////////////////////////
  // buffering
  //////////////////////////////

  // tx entries and the host credit count after reset
  localparam int unsigned uart_tx_depth = 4;
  // rx entries
  localparam int unsigned uart_rx_depth = 4;

  // one received byte
  // err set when the stop bit was sampled low
  typedef struct packed {
    logic [uart_dw-1:0] dat;
    logic               err;
  } uart_rx_t;

endpackage : uart_pkg

`default_nettype wire

/* logic/uart_ser.sv */
// uart serializer
// start bit, data lsb first, stop sequence at a runtime baud divisor

`timescale 1ns/10ps
`default_nettype none

module uart_ser (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // bit period is cfg_bdr+1 clocks
  input  wire logic [uart_pkg::uart_cw-1:0] cfg_bdr,
  // parallel stream in
  input  wire logic                        str_vld,
  input  wire logic [uart_pkg::uart_dw-1:0] str_dat,
  output logic                             str_rdy,
  // serial line
  output logic                             txd
);

  import uart_pkg::*;

  // byte taken this cycle
  logic str_trn;

  // baud counter
  logic [uart_cw-1:0] bdr_cnt;
  logic               bdr_end;

  // bit position within the frame
  logic [uart_bw-1:0] shf_cnt;
  logic               shf_end;
  logic               shf_run;

  // data plus start bit with ones shifting in from the top
  logic [uart_dw:0]   shf_dat;

  //////////////////////////////
  // stream side
  //////////////////////////////

  assign str_trn = str_vld & str_rdy;

  // ready in the last stop cycle too so frames follow without a gap
  assign str_rdy = ~shf_run | (shf_end & bdr_end);

  //////////////////////////////
  // baud timing
  //////////////////////////////

  // counts 0..cfg_bdr and restarts with each new frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
    end else if (str_trn) begin
      bdr_cnt <= '0;
    end else if (shf_run) begin
      bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
    end
  end

  // bit-end strobe
  assign bdr_end = shf_run & (bdr_cnt == cfg_bdr);

  //////////////////////////////
  // bit counter
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shf_cnt <= '0;
      shf_run <= 1'b0;
    end else if (str_trn) begin
      shf_cnt <= '0;
      shf_run <= 1'b1;
    end else if (bdr_end) begin
      if (shf_end) begin
        shf_cnt <= '0;
        shf_run <= 1'b0;
      end else begin
        shf_cnt <= shf_cnt + 1'b1;
      end
    end
  end

  // last stop bit
  assign shf_end = (shf_cnt == uart_bw'(uart_fl - 1));

  //////////////////////////////
  // shifter
  //////////////////////////////

  // reset to ones so the line idles high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shf_dat <= '1;
    end else if (str_trn) begin
      shf_dat <= {str_dat, 1'b0};
    end else if (bdr_end) begin
      shf_dat <= {1'b1, shf_dat[uart_dw:1]};
    end
  end

  assign txd = shf_dat[0];

  // between frames the register must have drained to all ones
  a_idle_high : assert property (
    @(posedge clk) disable iff (rst)
    !shf_run |-> txd
  ) else $error("uart_ser: txd low while idle");

endmodule : uart_ser

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the uart testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
  echo "verilator not found"
  exit 1
fi

verilator --binary --timing --assert -j 0 --top-module uart_tb -f files.f -o uart_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/uart_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
